/* build.f */
+incdir+src
src/hack_mem_pkg.sv
src/video_pkg.sv
src/screen_port_if.sv
src/memory_map.sv
src/data_ram.sv
src/screen_ram.sv
src/screen_scanner.sv
src/hack_memory.sv
tests/tb_hack_memory.sv

/* Bender.yml */
package:
  name: hack_memory

export_include_dirs:
  - src

sources:
  - files:
      - src/hack_mem_pkg.sv
      - src/video_pkg.sv
      - src/screen_port_if.sv
      - src/memory_map.sv
      - src/data_ram.sv
      - src/screen_ram.sv
      - src/screen_scanner.sv
      - src/hack_memory.sv
  - target: simulation
    files:
      - tests/tb_hack_memory.sv

/* tests/tb_hack_memory.sv */
`include "hack_settings.svh"

module tb_hack_memory;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int first_pixel_lat = 4; // enable edge, one edge to see it, two more to the pixel
    localparam int wait_limit      = 32;
    localparam int scan_pixels     = 2048;

    logic                clk;
    logic                rst;
    hack_mem_pkg::word_t in;
    hack_mem_pkg::addr_t address;
    logic                load;
    logic [7:0]          keyboard;
    hack_mem_pkg::word_t out;
    logic                scan_enable;
    logic                pixel;
    logic                pixel_valid;
    logic                frame_start;

    hack_mem_pkg::word_t shadow [0:`HACK_KBD_ADDR]; // mirror of ram and screen
    logic [15:0]         lfsr_state;
    logic [7:0]          kbd_val;
    hack_mem_pkg::word_t exp_next, exp_due; // expected out, two stage delay
    logic                exp_next_valid, exp_due_valid;
    int                  err_cnt, err_mark, tests_ok, tests_bad;

    hack_memory UUT (
        .clk(clk), .rst(rst), .in(in), .address(address), .load(load),
        .keyboard(keyboard), .out(out), .scan_enable(scan_enable),
        .pixel(pixel), .pixel_valid(pixel_valid), .frame_start(frame_start)
    );

    always #5 clk = ~clk;

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[14:0], lfsr_state[0]}; // one step per bit
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic hack_mem_pkg::region_e region_of(input hack_mem_pkg::addr_t a);
        if (a < `HACK_SCREEN_BASE) return hack_mem_pkg::region_ram;
        if (a < `HACK_SCREEN_BASE + `HACK_SCREEN_WORDS) return hack_mem_pkg::region_screen;
        if (a == `HACK_KBD_ADDR) return hack_mem_pkg::region_kbd;
        return hack_mem_pkg::region_none;
    endfunction

    // reference model, updates the shadow on stores and gives the expected out
    function automatic hack_mem_pkg::word_t ref_access(input hack_mem_pkg::addr_t a,
            input hack_mem_pkg::word_t d, input logic ld, input logic [7:0] kbd);
        hack_mem_pkg::region_e r;
        r = region_of(a);
        if (r == hack_mem_pkg::region_ram || r == hack_mem_pkg::region_screen) begin
            if (ld) shadow[a] = d; // write first
            return shadow[a];
        end
        if (r == hack_mem_pkg::region_kbd) return {8'h00, kbd};
        return '0;
    endfunction

    function automatic logic expected_pixel(input int p);
        hack_mem_pkg::word_t w;
        w = shadow[`HACK_SCREEN_BASE + p / 16];
        return w[p % 16]; // lsb is leftmost
    endfunction

    task automatic check_word(input string name, input hack_mem_pkg::word_t got,
            input hack_mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // out is due one cycle after the address, checked mid cycle
    always @(posedge clk) begin
        exp_due       <= exp_next;
        exp_due_valid <= exp_next_valid;
    end

    always @(negedge clk) begin
        if (exp_due_valid) check_word("out", out, exp_due);
    end

    task automatic bus_cycle(input hack_mem_pkg::addr_t a, input hack_mem_pkg::word_t d,
            input logic ld);
        @(posedge clk);
        address        <= a;
        in             <= d;
        load           <= ld;
        keyboard       <= kbd_val;
        exp_next       <= ref_access(a, d, ld, kbd_val);
        exp_next_valid <= 1'b1;
    endtask

    // ram and screen words that share the low address bits of a
    task automatic read_aliases(input hack_mem_pkg::addr_t a);
        bus_cycle(a % `HACK_RAM_WORDS, '0, 1'b0);
        bus_cycle(`HACK_SCREEN_BASE + (a - `HACK_SCREEN_BASE) % `HACK_SCREEN_WORDS, '0, 1'b0);
    endtask

    task automatic flush_bus();
        repeat (2) begin
            @(posedge clk);
            load           <= 1'b0;
            exp_next_valid <= 1'b0; // nothing more to compare
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    task automatic ram_random_test();
        hack_mem_pkg::addr_t addrs [$];
        hack_mem_pkg::addr_t a;
        for (int i = 0; i < 64; i++) begin
            a = rand_bits(14); // anywhere in data ram
            addrs.push_back(a);
            bus_cycle(a, rand_bits(16), 1'b1);
        end
        while (addrs.size() > 0) bus_cycle(addrs.pop_back(), rand_bits(16), 1'b0);
        flush_bus();
        end_test("ram random");
    endtask

    task automatic screen_isolation_test();
        for (int w = 0; w < 128; w++) begin
            bus_cycle(w, rand_bits(16), 1'b1);                      // ram word
            bus_cycle(`HACK_SCREEN_BASE + w, rand_bits(16), 1'b1);  // screen word, same offset
        end
        for (int w = 0; w < 128; w++) begin
            bus_cycle(w, '0, 1'b0);
            bus_cycle(`HACK_SCREEN_BASE + w, '0, 1'b0);
        end
        flush_bus();
        end_test("screen");
    endtask

    task automatic kbd_unmapped_test();
        hack_mem_pkg::addr_t a;
        for (int i = 0; i < 16; i++) begin
            kbd_val = rand_bits(8);
            bus_cycle(`HACK_KBD_ADDR, rand_bits(16), i[0]); // odd ones try a store
            a = `HACK_KBD_ADDR + 1 + rand_bits(13) % 8191;     // above the keyboard
            bus_cycle(a, rand_bits(16), i[0]);
            bus_cycle(a, '0, 1'b0);
            read_aliases(`HACK_KBD_ADDR); // a leaked store would show up here
            read_aliases(a);
        end
        flush_bus();
        end_test("keyboard and unmapped");
    endtask

    task automatic write_read_test();
        hack_mem_pkg::addr_t a;
        for (int i = 0; i < 32; i++) begin
            a = rand_bits(1) ? `HACK_SCREEN_BASE + rand_bits(13) : rand_bits(14);
            bus_cycle(a, rand_bits(16), 1'b1);
            bus_cycle(a, rand_bits(16), 1'b0); // back to back read
        end
        flush_bus();
        end_test("write then read");
    endtask

    task automatic scan_test();
        int   n;
        logic seen;
        @(posedge clk);
        scan_enable <= 1'b1;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = pixel_valid;
        end
        if (!seen) begin
            $display("pixel_valid never went high after scan_enable was raised");
            err_cnt++;
        end else begin
            if (n != first_pixel_lat) begin
                $display("Mismatch at %0t: first pixel latency = %0d, expected %0d",
                         $time, n, first_pixel_lat);
                err_cnt++;
            end
            for (int p = 0; p < scan_pixels; p++) begin
                if (p > 0) @(negedge clk);
                check_bit("pixel_valid", pixel_valid, 1'b1); // no gaps
                check_bit("frame_start", frame_start, p == 0);
                check_bit("pixel", pixel, expected_pixel(p));
            end
        end
        @(posedge clk);
        scan_enable <= 1'b0;
        n = 0;
        while (seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = pixel_valid;
        end
        if (seen) begin
            $display("pixel_valid stayed high after scan_enable was dropped");
            err_cnt++;
        end
        end_test("scan");
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        in             = '0;
        address        = 15'h7fff; // unmapped, keeps out at 0
        load           = 1'b0;
        keyboard       = '0;
        scan_enable    = 1'b0;
        kbd_val        = '0;
        lfsr_state     = 16'd62;
        exp_next       = '0;
        exp_next_valid = 1'b0;
        exp_due        = '0;
        exp_due_valid  = 1'b0;
        err_cnt        = 0;
        err_mark       = 0;
        tests_ok       = 0;
        tests_bad      = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("pixel_valid", pixel_valid, 1'b0);
        check_bit("frame_start", frame_start, 1'b0);
        check_word("out", out, '0);
        end_test("reset");
        ram_random_test();
        screen_isolation_test();
        kbd_unmapped_test();
        write_read_test();
        scan_test();
        $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src/hack_memory.sv */
`include "hack_settings.svh"

module hack_memory (
    input  logic                clk,
    input  logic                rst,
    input  hack_mem_pkg::word_t in,          // cpu store data
    input  hack_mem_pkg::addr_t address,     // cpu word address
    input  logic                load,        // cpu store strobe
    input  logic [7:0]          keyboard,    // key code from the keyboard
    output hack_mem_pkg::word_t out,         // cpu read data
    input  logic                scan_enable,
    output logic                pixel,
    output logic                pixel_valid,
    output logic                frame_start
);

    logic [$clog2(`HACK_RAM_WORDS)-1:0] ram_addr;
    hack_mem_pkg::word_t                ram_d;
    logic                               ram_we;
    hack_mem_pkg::word_t                ram_q;
    video_pkg::screen_addr_t            scan_addr;
    hack_mem_pkg::word_t                scan_q;

    screen_port_if scr (); // bus port of the screen buffer

    // decoder, writes both rams and picks read data
    memory_map u_memory_map (
        .clk      (clk),
        .rst      (rst),
        .in       (in),
        .address  (address),
        .load     (load),
        .keyboard (keyboard),
        .out      (out),
        .ram_addr (ram_addr),
        .ram_d    (ram_d),
        .ram_we   (ram_we),
        .ram_q    (ram_q),
        .scr      (scr.bus)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .addr (ram_addr),
        .d    (ram_d),
        .we   (ram_we),
        .q    (ram_q)
    );

    screen_ram u_screen_ram (
        .clk       (clk),
        .bus       (scr.mem),
        .scan_addr (scan_addr),
        .scan_q    (scan_q)
    );

    screen_scanner u_screen_scanner (
        .clk         (clk),
        .rst         (rst),
        .scan_enable (scan_enable),
        .scan_addr   (scan_addr),
        .scan_q      (scan_q),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start)
    );

endmodule

/* src/screen_scanner.sv */
`include "hack_settings.svh"

module screen_scanner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    scan_enable, // level, low parks the scanner
    output video_pkg::screen_addr_t scan_addr,   // word being fetched
    input  hack_mem_pkg::word_t     scan_q,      // screen word, one cycle after scan_addr
    output logic                    pixel,
    output logic                    pixel_valid,
    output logic                    frame_start  // with pixel 0 of a frame
);

    video_pkg::scan_state_e state;
    video_pkg::bit_idx_t    bit_idx;   // pixel of the word now on the output
    hack_mem_pkg::word_t    shift_reg; // word being serialized
    logic                   load_word; // take scan_q into the shift register
    logic                   prefetch;  // step scan_addr to the next word

    // load on the first shift cycle, then after the 16th pixel
    assign load_word = (state == video_pkg::scan_shift) && (!pixel_valid || bit_idx == 4'd15);

    // two pixels ahead: addr out during pixel 14, data in scan_q during 15
    assign prefetch = pixel_valid && (bit_idx == 4'd13);

    always_ff @(posedge clk) begin
        if (rst || !scan_enable) begin
            state       <= video_pkg::scan_idle;
            scan_addr   <= '0; // next frame starts at word 0
            bit_idx     <= '0;
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            case (state)
                video_pkg::scan_idle:  state <= video_pkg::scan_fetch;
                video_pkg::scan_fetch: state <= video_pkg::scan_shift; // word 0 addr is out
                default:               state <= video_pkg::scan_shift;
            endcase

            pixel_valid <= (state == video_pkg::scan_shift); // first load sets it

            if (load_word) begin
                bit_idx <= '0;
            end else if (pixel_valid) begin
                bit_idx <= bit_idx + 4'd1;
            end

            if (prefetch) begin
                if (scan_addr == video_pkg::screen_addr_t'(`HACK_SCREEN_WORDS - 1)) begin
                    scan_addr <= '0; // frame wrap
                end else begin
                    scan_addr <= scan_addr + 1'b1;
                end
            end

            // scan_addr still names the word being loaded at this edge
            frame_start <= load_word && (scan_addr == '0);
        end
    end

    // serializer, lsb is the leftmost pixel
    always_ff @(posedge clk) begin
        if (load_word) begin
            shift_reg <= scan_q;
        end else if (pixel_valid) begin
            shift_reg <= {1'b0, shift_reg[15:1]};
        end
    end

    assign pixel = shift_reg[0];

endmodule

/* src/screen_ram.sv */
`include "hack_settings.svh"

module screen_ram (
    input  logic                    clk,
    screen_port_if.mem              bus,       // cpu side, read/write
    input  video_pkg::screen_addr_t scan_addr, // scanner side, read only
    output hack_mem_pkg::word_t     scan_q
);

    hack_mem_pkg::word_t mem [`HACK_SCREEN_WORDS]; // 8K x 16 frame buffer

    // bus port, write first like the data ram
    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.data;
            bus.q         <= bus.data;
        end else begin
            bus.q <= mem[bus.addr];
        end
    end

    // scan port
    // a same-cycle bus store to this word shows the old value here
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr]; // one cycle latency
    end

endmodule

/* src/data_ram.sv */
`include "hack_settings.svh"

module data_ram (
    input  logic                              clk,
    input  logic [$clog2(`HACK_RAM_WORDS)-1:0] addr,
    input  hack_mem_pkg::word_t               d,
    input  logic                              we,
    output hack_mem_pkg::word_t               q     // registered read
);

    hack_mem_pkg::word_t mem [`HACK_RAM_WORDS]; // 16K x 16

    // single port, write first
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= d;
            q         <= d; // store data shows up on the read side too
        end else begin
            q <= mem[addr];
        end
    end

endmodule

/* src/memory_map.sv */
`include "hack_settings.svh"

module memory_map (
    input  logic                              clk,
    input  logic                              rst,
    input  hack_mem_pkg::word_t               in,       // store data from cpu
    input  hack_mem_pkg::addr_t               address,
    input  logic                              load,     // store strobe
    input  logic [7:0]                        keyboard, // current key code
    output hack_mem_pkg::word_t               out,      // read data, one cycle late
    output logic [$clog2(`HACK_RAM_WORDS)-1:0] ram_addr,
    output hack_mem_pkg::word_t               ram_d,
    output logic                              ram_we,
    input  hack_mem_pkg::word_t               ram_q,
    screen_port_if.bus                        scr
);

    hack_mem_pkg::region_e region;   // decode of current address
    hack_mem_pkg::region_e region_q; // decode of last cycle's address
    hack_mem_pkg::addr_t   scr_offset;
    logic [7:0]            kbd_q;    // keyboard sampled with the read

    // address decode, ranges checked low to high
    always_comb begin
        if (address < hack_mem_pkg::addr_t'(`HACK_RAM_WORDS)) begin
            region = hack_mem_pkg::region_ram;
        end else if (address < hack_mem_pkg::addr_t'(`HACK_SCREEN_BASE + `HACK_SCREEN_WORDS)) begin
            region = hack_mem_pkg::region_screen;
        end else if (address == hack_mem_pkg::addr_t'(`HACK_KBD_ADDR)) begin
            region = hack_mem_pkg::region_kbd;
        end else begin
            region = hack_mem_pkg::region_none; // above the keyboard
        end
    end

    // screen offset, only meaningful when region is screen
    assign scr_offset = address - hack_mem_pkg::addr_t'(`HACK_SCREEN_BASE);

    // data ram side
    assign ram_addr = address[$clog2(`HACK_RAM_WORDS)-1:0];
    assign ram_d    = in;
    assign ram_we   = load && (region == hack_mem_pkg::region_ram);

    // screen side
    assign scr.addr = scr_offset[$bits(video_pkg::screen_addr_t)-1:0];
    assign scr.data = in;
    assign scr.we   = load && (region == hack_mem_pkg::region_screen);
    // keyboard and unmapped stores just fall through, no enable

    // region follows the ram read by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            region_q <= hack_mem_pkg::region_none; // out reads 0 after reset
        end else begin
            region_q <= region;
        end
    end

    always_ff @(posedge clk) begin
        kbd_q <= keyboard; // same edge as the ram reads
    end

    // read mux, lined up with the registered ram outputs
    always_comb begin
        case (region_q)
            hack_mem_pkg::region_ram:    out = ram_q;
            hack_mem_pkg::region_screen: out = scr.q;
            hack_mem_pkg::region_kbd:    out = {8'h00, kbd_q};
            default:                     out = '0;
        endcase
    end

endmodule

/* src/screen_port_if.sv */
// bus side of the screen ram, one read/write port
interface screen_port_if;

    video_pkg::screen_addr_t addr; // offset from screen base
    hack_mem_pkg::word_t     data; // store data
    logic                    we;   // store strobe
    hack_mem_pkg::word_t     q;    // read data, one cycle late

    modport bus (
        output addr,
        output data,
        output we,
        input  q
    );

    modport mem (
        input  addr,
        input  data,
        input  we,
        output q
    );

endinterface

/* src/video_pkg.sv */
`include "hack_settings.svh"

package video_pkg;

    // scanner fsm
    typedef enum logic [1:0] {
        scan_idle,  // waiting for scan_enable
        scan_fetch, // first word address out
        scan_shift  // streaming pixels
    } scan_state_e;

    // word index into the screen buffer, 8K words
    typedef logic [$clog2(`HACK_WORDS_PER_LINE * `HACK_LINES)-1:0] screen_addr_t;
    typedef logic [3:0] bit_idx_t; // pixel within a word

endpackage

/* src/hack_mem_pkg.sv */
package hack_mem_pkg;

    // cpu side bus types
    typedef logic [15:0] word_t; // data word
    typedef logic [14:0] addr_t; // word address

    // which part of the map an address falls into
    typedef enum logic [1:0] {
        region_ram,    // data ram
        region_screen, // screen buffer
        region_kbd,    // keyboard register
        region_none    // unmapped, reads 0
    } region_e;

endpackage

/* src/hack_settings.svh */
`ifndef HACK_SETTINGS_SVH
`define HACK_SETTINGS_SVH

// hack memory map, word addresses on the 15-bit bus
`define HACK_RAM_WORDS      16384 // data ram, 0 .. 16383
`define HACK_SCREEN_BASE    16384 // first screen word
`define HACK_SCREEN_WORDS   8192  // screen buffer, 16384 .. 24575
`define HACK_KBD_ADDR       24576 // keyboard register, read only

// screen geometry, 512 x 256 mono
`define HACK_WORDS_PER_LINE 32    // 16 pixels per word
`define HACK_LINES          256

`endif
